// File: Bender.yml
package:
  name: fetch_mem

sources:
  - source/cache_pkg.sv
  - source/bus_pkg.sv
  - source/icache.sv
  - source/data_port.sv
  - source/bus_arbiter.sv
  - source/main_memory.sv
  - source/fetch_mem_top.sv
  - target: test
    files:
      - tb/tb_fetch_mem.sv

// File: fetch_mem.f
source/cache_pkg.sv
source/bus_pkg.sv
source/icache.sv
source/data_port.sv
source/bus_arbiter.sv
source/main_memory.sv
source/fetch_mem_top.sv
tb/tb_fetch_mem.sv

// File: source/bus_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter (
	input  wire logic                              clock,
	input  wire logic                              reset,

	input  wire logic                              ic_req_valid_i,
	input  wire logic [bus_pkg::ADDR_WIDTH-1:0]    ic_req_addr_i,
	input  wire logic [bus_pkg::LEN_WIDTH-1:0]     ic_req_len_i,
	output logic                                   ic_beat_o,
	output logic                                   ic_beat_last_o,

	input  wire logic                              dp_req_valid_i,
	input  wire logic                              dp_req_write_i,
	input  wire logic [bus_pkg::ADDR_WIDTH-1:0]    dp_req_addr_i,
	input  wire logic [bus_pkg::DATA_WIDTH-1:0]    dp_req_wdata_i,
	input  wire logic [bus_pkg::STRB_WIDTH-1:0]    dp_req_wstrb_i,
	output logic                                   dp_beat_o,

	output logic                                   mem_valid_o,
	output bus_pkg::bus_op_e                       mem_op_o,
	output logic [bus_pkg::ADDR_WIDTH-1:0]         mem_addr_o,
	output logic [bus_pkg::LEN_WIDTH-1:0]          mem_len_o,
	output logic [bus_pkg::DATA_WIDTH-1:0]         mem_wdata_o,
	output logic [bus_pkg::STRB_WIDTH-1:0]         mem_wstrb_o,
	input  wire logic                              mem_ready_i,
	input  wire logic                              mem_beat_i,
	input  wire logic                              mem_last_i
);

	bus_pkg::bus_owner_e owner_q;
	bus_pkg::bus_owner_e pick;
	logic                accepted_q; // command taken, beats pending
	logic                last_ic_q;  // icache won the previous transaction
	logic                is_data;

	always_comb begin
		if (ic_req_valid_i && dp_req_valid_i)
			pick = last_ic_q ? bus_pkg::OWNER_DATA : bus_pkg::OWNER_ICACHE;
		else if (ic_req_valid_i)
			pick = bus_pkg::OWNER_ICACHE;
		else if (dp_req_valid_i)
			pick = bus_pkg::OWNER_DATA;
		else
			pick = bus_pkg::OWNER_NONE;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			owner_q <= bus_pkg::OWNER_NONE;
			accepted_q <= 1'b0;
			last_ic_q <= 1'b0;
		end else if (owner_q == bus_pkg::OWNER_NONE) begin
			owner_q <= pick;
		end else if (!accepted_q) begin
			if (mem_ready_i)
				accepted_q <= 1'b1;
		end else if (mem_beat_i && mem_last_i) begin
			owner_q <= bus_pkg::OWNER_NONE;
			accepted_q <= 1'b0;
			last_ic_q <= (owner_q == bus_pkg::OWNER_ICACHE);
		end
	end

	assign is_data = (owner_q == bus_pkg::OWNER_DATA);

	// command mux
	assign mem_valid_o = (owner_q != bus_pkg::OWNER_NONE) && !accepted_q;
	assign mem_op_o = (is_data && dp_req_write_i) ? bus_pkg::BUS_WRITE : bus_pkg::BUS_READ;
	assign mem_addr_o = is_data ? dp_req_addr_i : ic_req_addr_i;
	assign mem_len_o = is_data ? '0 : ic_req_len_i; // data port is always single beat
	assign mem_wdata_o = dp_req_wdata_i;
	assign mem_wstrb_o = (is_data && dp_req_write_i) ? dp_req_wstrb_i : '0;

	assign ic_beat_o = mem_beat_i && (owner_q == bus_pkg::OWNER_ICACHE);
	assign ic_beat_last_o = ic_beat_o && mem_last_i;
	assign dp_beat_o = mem_beat_i && is_data;

	// the granted requester keeps its request up until its last beat
	owner_held: assert property (@(posedge clock) disable iff (reset)
		accepted_q |-> (is_data ? dp_req_valid_i : ic_req_valid_i));

endmodule

`default_nettype wire

// File: source/bus_pkg.sv
`default_nettype none

package bus_pkg;

	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int STRB_WIDTH = DATA_WIDTH / 8;

	// burst length field holds beats minus one
	localparam int LEN_WIDTH = 8;
	localparam int BURST_LEN = 4;

	typedef enum logic {
		BUS_READ,
		BUS_WRITE
	} bus_op_e;

	typedef enum logic [1:0] {
		OWNER_NONE,
		OWNER_ICACHE,
		OWNER_DATA
	} bus_owner_e;

endpackage

`default_nettype wire

// File: source/cache_pkg.sv
`default_nettype none

package cache_pkg;

	// line geometry
	localparam int OFFSET_BITS = 4; // 16-byte lines
	localparam int WORDS_PER_LINE = 4;
	localparam int WORD_SEL_BITS = $clog2(WORDS_PER_LINE);
	localparam int LINE_WIDTH = WORDS_PER_LINE * 32;

	// associativity
	localparam int WAYS = 4;
	localparam int WAY_BITS = $clog2(WAYS);

	typedef enum logic [1:0] {
		IC_IDLE,
		IC_LOOKUP, // tag compare, hit answered one cycle later
		IC_REFILL, // burst read of the missing line
		IC_FENCE
	} icache_state_e;

endpackage

`default_nettype wire

// File: source/data_port.sv
`timescale 1ns/10ps
`default_nettype none

module data_port (
	input  wire logic                              clock,
	input  wire logic                              reset,

	input  wire logic                              dreq_valid_i,
	input  wire logic                              dreq_write_i,
	input  wire logic [bus_pkg::ADDR_WIDTH-1:0]    dreq_addr_i,
	input  wire logic [bus_pkg::DATA_WIDTH-1:0]    dreq_wdata_i,
	input  wire logic [bus_pkg::STRB_WIDTH-1:0]    dreq_wstrb_i,
	output logic                                   dreq_ready_o,
	output logic [bus_pkg::DATA_WIDTH-1:0]         dreq_rdata_o,

	output logic                                   bus_req_valid_o,
	output logic                                   bus_req_write_o,
	output logic [bus_pkg::ADDR_WIDTH-1:0]         bus_req_addr_o,
	output logic [bus_pkg::DATA_WIDTH-1:0]         bus_req_wdata_o,
	output logic [bus_pkg::STRB_WIDTH-1:0]         bus_req_wstrb_o,
	input  wire logic                              bus_beat_i,
	input  wire logic [bus_pkg::DATA_WIDTH-1:0]    bus_rdata_i
);

	typedef enum logic [1:0] {
		DP_IDLE,
		DP_BUS,  // request held on the bus
		DP_RESP  // ready pulse to the core
	} dp_state_e;

	dp_state_e state_q;

	logic [bus_pkg::DATA_WIDTH-1:0] rdata_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= DP_IDLE;
		end else begin
			case (state_q)
				DP_IDLE: if (dreq_valid_i) state_q <= DP_BUS;
				DP_BUS:  if (bus_beat_i) state_q <= DP_RESP;
				default: state_q <= DP_IDLE;
			endcase
		end
	end

	// holding registers for the access in flight
	always_ff @(posedge clock) begin
		if (state_q == DP_IDLE && dreq_valid_i) begin
			bus_req_write_o <= dreq_write_i;
			bus_req_addr_o <= dreq_addr_i;
			bus_req_wdata_o <= dreq_wdata_i;
			bus_req_wstrb_o <= dreq_wstrb_i;
		end
		if (state_q == DP_BUS && bus_beat_i)
			rdata_q <= bus_rdata_i; // don't care on stores
	end

	assign bus_req_valid_o = (state_q == DP_BUS);
	assign dreq_ready_o = (state_q == DP_RESP);
	assign dreq_rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: source/fetch_mem_top.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_mem_top #(
	parameter int SET_BITS    = 4,
	parameter int MEM_WORDS   = 1024,
	parameter int MEM_LATENCY = 2
) (
	input  wire logic                              clock,
	input  wire logic                              reset,

	input  wire logic                              ifu_valid_i,
	input  wire logic [31:0]                       ifu_addr_i,
	input  wire logic                              ifu_fence_i,
	output logic                                   ifu_ready_o,
	output logic [31:0]                            ifu_data_o,

	input  wire logic                              dreq_valid_i,
	input  wire logic                              dreq_write_i,
	input  wire logic [bus_pkg::ADDR_WIDTH-1:0]    dreq_addr_i,
	input  wire logic [bus_pkg::DATA_WIDTH-1:0]    dreq_wdata_i,
	input  wire logic [bus_pkg::STRB_WIDTH-1:0]    dreq_wstrb_i,
	output logic                                   dreq_ready_o,
	output logic [bus_pkg::DATA_WIDTH-1:0]         dreq_rdata_o
);

	// icache request side
	logic                           ic_req_valid;
	logic [bus_pkg::ADDR_WIDTH-1:0] ic_req_addr;
	logic [bus_pkg::LEN_WIDTH-1:0]  ic_req_len;
	logic                           ic_beat;
	logic                           ic_beat_last;

	// data port request side
	logic                           dp_req_valid;
	logic                           dp_req_write;
	logic [bus_pkg::ADDR_WIDTH-1:0] dp_req_addr;
	logic [bus_pkg::DATA_WIDTH-1:0] dp_req_wdata;
	logic [bus_pkg::STRB_WIDTH-1:0] dp_req_wstrb;
	logic                           dp_beat;

	// arbiter to memory
	logic                           mem_valid;
	bus_pkg::bus_op_e               mem_op;
	logic [bus_pkg::ADDR_WIDTH-1:0] mem_addr;
	logic [bus_pkg::LEN_WIDTH-1:0]  mem_len;
	logic [bus_pkg::DATA_WIDTH-1:0] mem_wdata;
	logic [bus_pkg::STRB_WIDTH-1:0] mem_wstrb;
	logic                           mem_ready;
	logic                           mem_beat;
	logic                           mem_last;
	logic [bus_pkg::DATA_WIDTH-1:0] mem_rdata; // shared by both requesters

	icache #(.SET_BITS(SET_BITS)) u_icache (
		.clock, .reset,
		.ifu_valid_i, .ifu_addr_i, .ifu_fence_i, .ifu_ready_o, .ifu_data_o,
		.bus_req_valid_o(ic_req_valid), .bus_req_addr_o(ic_req_addr),
		.bus_req_len_o(ic_req_len), .bus_beat_i(ic_beat),
		.bus_beat_last_i(ic_beat_last), .bus_rdata_i(mem_rdata)
	);

	data_port u_data_port (
		.clock, .reset,
		.dreq_valid_i, .dreq_write_i, .dreq_addr_i, .dreq_wdata_i, .dreq_wstrb_i,
		.dreq_ready_o, .dreq_rdata_o,
		.bus_req_valid_o(dp_req_valid), .bus_req_write_o(dp_req_write),
		.bus_req_addr_o(dp_req_addr), .bus_req_wdata_o(dp_req_wdata),
		.bus_req_wstrb_o(dp_req_wstrb), .bus_beat_i(dp_beat), .bus_rdata_i(mem_rdata)
	);

	bus_arbiter u_bus_arbiter (
		.clock, .reset,
		.ic_req_valid_i(ic_req_valid), .ic_req_addr_i(ic_req_addr), .ic_req_len_i(ic_req_len),
		.ic_beat_o(ic_beat), .ic_beat_last_o(ic_beat_last),
		.dp_req_valid_i(dp_req_valid), .dp_req_write_i(dp_req_write),
		.dp_req_addr_i(dp_req_addr), .dp_req_wdata_i(dp_req_wdata),
		.dp_req_wstrb_i(dp_req_wstrb), .dp_beat_o(dp_beat),
		.mem_valid_o(mem_valid), .mem_op_o(mem_op), .mem_addr_o(mem_addr),
		.mem_len_o(mem_len), .mem_wdata_o(mem_wdata), .mem_wstrb_o(mem_wstrb),
		.mem_ready_i(mem_ready), .mem_beat_i(mem_beat), .mem_last_i(mem_last)
	);

	main_memory #(.MEM_WORDS(MEM_WORDS), .MEM_LATENCY(MEM_LATENCY)) u_main_memory (
		.clock, .reset,
		.mem_valid_i(mem_valid), .mem_op_i(mem_op), .mem_addr_i(mem_addr),
		.mem_len_i(mem_len), .mem_wdata_i(mem_wdata), .mem_wstrb_i(mem_wstrb),
		.mem_ready_o(mem_ready), .mem_beat_o(mem_beat), .mem_last_o(mem_last),
		.mem_rdata_o(mem_rdata)
	);

endmodule

`default_nettype wire

// File: source/icache.sv
`timescale 1ns/10ps
`default_nettype none

module icache #(
	parameter int SET_BITS = 4
) (
	input  wire logic                              clock,
	input  wire logic                              reset,

	input  wire logic                              ifu_valid_i,
	input  wire logic [31:0]                       ifu_addr_i,
	input  wire logic                              ifu_fence_i,
	output logic                                   ifu_ready_o,
	output logic [31:0]                            ifu_data_o,

	output logic                                   bus_req_valid_o,
	output logic [bus_pkg::ADDR_WIDTH-1:0]         bus_req_addr_o,
	output logic [bus_pkg::LEN_WIDTH-1:0]          bus_req_len_o,
	input  wire logic                              bus_beat_i,
	input  wire logic                              bus_beat_last_i,
	input  wire logic [bus_pkg::DATA_WIDTH-1:0]    bus_rdata_i
);

	localparam int SETS = 2 ** SET_BITS;
	localparam int TAG_BITS = 32 - cache_pkg::OFFSET_BITS - SET_BITS;

	cache_pkg::icache_state_e state_q;

	logic [cache_pkg::LINE_WIDTH-1:0] data_ram [cache_pkg::WAYS][SETS];
	logic [TAG_BITS-1:0]              tag_ram  [cache_pkg::WAYS][SETS];
	logic [cache_pkg::WAYS-1:0]       valid_q  [SETS];

	// address fields
	logic [TAG_BITS-1:0]                 addr_tag;
	logic [SET_BITS-1:0]                 addr_set;
	logic [cache_pkg::WORD_SEL_BITS-1:0] word_sel;

	logic [cache_pkg::WAYS-1:0]       hit;
	logic [cache_pkg::LINE_WIDTH-1:0] hit_line;
	logic [31:0]                      hit_word;
	logic [31:0]                      crit_word;
	logic                             hit_ack_q;

	logic [cache_pkg::LINE_WIDTH-1:0] line_buf_q;
	logic [TAG_BITS-1:0]              refill_tag_q;
	logic [SET_BITS-1:0]              refill_set_q;
	logic                             wen_q;
	logic [cache_pkg::WAY_BITS-1:0]   victim_q;
	logic                             last_beat;

	assign addr_tag = ifu_addr_i[31 -: TAG_BITS];
	assign addr_set = ifu_addr_i[cache_pkg::OFFSET_BITS +: SET_BITS];
	assign word_sel = ifu_addr_i[cache_pkg::OFFSET_BITS-1 -: cache_pkg::WORD_SEL_BITS];

	always_comb begin
		hit_line = '0;
		for (int w = 0; w < cache_pkg::WAYS; w++) begin
			hit[w] = valid_q[addr_set][w] && (tag_ram[w][addr_set] == addr_tag);
			if (hit[w])
				hit_line = hit_line | data_ram[w][addr_set];
		end
	end

	assign hit_word = hit_line[32*word_sel +: 32];

	// beats so far sit in the upper words, the final one is still on the bus
	always_comb begin
		crit_word = bus_rdata_i;
		for (int k = 0; k < cache_pkg::WORDS_PER_LINE - 1; k++) begin
			if (word_sel == k)
				crit_word = line_buf_q[32*(k+1) +: 32];
		end
	end

	assign last_beat = (state_q == cache_pkg::IC_REFILL) && bus_beat_i && bus_beat_last_i;

	assign ifu_ready_o = hit_ack_q || last_beat;
	assign ifu_data_o = (state_q == cache_pkg::IC_REFILL) ? crit_word : hit_word;

	assign bus_req_valid_o = (state_q == cache_pkg::IC_REFILL);
	assign bus_req_addr_o = {refill_tag_q, refill_set_q, {cache_pkg::OFFSET_BITS{1'b0}}};
	assign bus_req_len_o = bus_pkg::LEN_WIDTH'(bus_pkg::BURST_LEN - 1);

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= cache_pkg::IC_IDLE;
			hit_ack_q <= 1'b0;
			wen_q <= 1'b0;
			victim_q <= '0;
		end else begin
			victim_q <= victim_q + 1'b1; // free running, used as random victim
			wen_q <= last_beat;
			hit_ack_q <= 1'b0;
			case (state_q)
				cache_pkg::IC_IDLE: begin
					if (ifu_valid_i)
						state_q <= cache_pkg::IC_LOOKUP;
					else if (ifu_fence_i)
						state_q <= cache_pkg::IC_FENCE;
				end
				cache_pkg::IC_LOOKUP: begin
					if (hit_ack_q)
						state_q <= cache_pkg::IC_IDLE;
					else if (|hit)
						hit_ack_q <= 1'b1;
					else
						state_q <= cache_pkg::IC_REFILL;
				end
				cache_pkg::IC_REFILL: begin
					if (last_beat)
						state_q <= cache_pkg::IC_IDLE; // line write lands in the idle cycle
				end
				default: state_q <= cache_pkg::IC_IDLE;
			endcase
		end
	end

	// refill target is latched so the core may move on once it has its word
	always_ff @(posedge clock) begin
		if (state_q == cache_pkg::IC_LOOKUP) begin
			refill_tag_q <= addr_tag;
			refill_set_q <= addr_set;
		end
		if (state_q == cache_pkg::IC_REFILL && bus_beat_i)
			line_buf_q <= {bus_rdata_i, line_buf_q[cache_pkg::LINE_WIDTH-1:32]};
	end

	always_ff @(posedge clock) begin
		if (wen_q) begin
			data_ram[victim_q][refill_set_q] <= line_buf_q;
			tag_ram[victim_q][refill_set_q] <= refill_tag_q;
		end
	end

	always_ff @(posedge clock) begin
		if (reset || state_q == cache_pkg::IC_FENCE) begin
			for (int s = 0; s < SETS; s++)
				valid_q[s] <= '0;
		end else if (wen_q) begin
			valid_q[refill_set_q][victim_q] <= 1'b1;
		end
	end

	// a line is only filled after a miss, so it can never sit in two ways
	hit_onehot: assert property (@(posedge clock) disable iff (reset)
		state_q == cache_pkg::IC_LOOKUP |-> $onehot0(hit));

endmodule

`default_nettype wire

// File: source/main_memory.sv
`timescale 1ns/10ps
`default_nettype none

module main_memory #(
	parameter int MEM_WORDS   = 1024,
	parameter int MEM_LATENCY = 2
) (
	input  wire logic                              clock,
	input  wire logic                              reset,

	input  wire logic                              mem_valid_i,
	input  wire bus_pkg::bus_op_e                  mem_op_i,
	input  wire logic [bus_pkg::ADDR_WIDTH-1:0]    mem_addr_i,
	input  wire logic [bus_pkg::LEN_WIDTH-1:0]     mem_len_i,
	input  wire logic [bus_pkg::DATA_WIDTH-1:0]    mem_wdata_i,
	input  wire logic [bus_pkg::STRB_WIDTH-1:0]    mem_wstrb_i,
	output logic                                   mem_ready_o,
	output logic                                   mem_beat_o,
	output logic                                   mem_last_o,
	output logic [bus_pkg::DATA_WIDTH-1:0]         mem_rdata_o
);

	localparam int IDX_BITS = $clog2(MEM_WORDS);
	localparam int CNT_BITS = $clog2(MEM_LATENCY + 1);

	typedef enum logic [1:0] {MS_IDLE, MS_WAIT, MS_XFER} mem_state_e;

	mem_state_e state_q;

	logic [bus_pkg::DATA_WIDTH-1:0] mem [MEM_WORDS];

	logic [CNT_BITS-1:0]              cnt_q;
	logic [bus_pkg::LEN_WIDTH-1:0]    beat_q;
	bus_pkg::bus_op_e                 op_q;
	logic [bus_pkg::ADDR_WIDTH-3:0]   word_q;
	logic [bus_pkg::LEN_WIDTH-1:0]    len_q;
	logic [bus_pkg::DATA_WIDTH-1:0]   wdata_q;
	logic [bus_pkg::STRB_WIDTH-1:0]   wstrb_q;

	initial begin
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = (i * 4) ^ 32'h5A5A0000;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= MS_IDLE;
			mem_ready_o <= 1'b0;
		end else begin
			mem_ready_o <= 1'b0;
			case (state_q)
				MS_IDLE: begin
					if (mem_valid_i) begin
						mem_ready_o <= 1'b1;
						cnt_q <= CNT_BITS'(MEM_LATENCY);
						beat_q <= '0;
						state_q <= MS_WAIT;
					end
				end
				MS_WAIT: begin
					cnt_q <= cnt_q - 1'b1;
					if (cnt_q == 1)
						state_q <= MS_XFER;
				end
				MS_XFER: begin
					beat_q <= beat_q + 1'b1;
					if (mem_last_o)
						state_q <= MS_IDLE;
				end
				default: state_q <= MS_IDLE;
			endcase
		end
	end

	// command capture
	always_ff @(posedge clock) begin
		if (state_q == MS_IDLE && mem_valid_i) begin
			op_q <= mem_op_i;
			word_q <= mem_addr_i[bus_pkg::ADDR_WIDTH-1:2];
			len_q <= mem_len_i;
			wdata_q <= mem_wdata_i;
			wstrb_q <= mem_wstrb_i;
		end else if (state_q == MS_XFER) begin
			word_q <= word_q + 1'b1; // next word of the burst
		end
	end

	always @(posedge clock) begin
		if (state_q == MS_XFER && op_q == bus_pkg::BUS_WRITE) begin
			for (int b = 0; b < bus_pkg::STRB_WIDTH; b++) begin
				if (wstrb_q[b])
					mem[word_q[IDX_BITS-1:0]][8*b +: 8] <= wdata_q[8*b +: 8];
			end
		end
	end

	assign mem_beat_o = (state_q == MS_XFER);
	assign mem_last_o = mem_beat_o && (op_q == bus_pkg::BUS_WRITE || beat_q == len_q);
	assign mem_rdata_o = mem[word_q[IDX_BITS-1:0]];

	// whole burst must fit in the array
	addr_in_range: assert property (@(posedge clock) disable iff (reset)
		mem_ready_o |-> (32'(word_q) + 32'(len_q)) < MEM_WORDS);

endmodule

`default_nettype wire

// File: tb/fetch_cases.txt
# op addr wdata strobe expected, all hex; memory word at A is A xor 5a5a0000
# store ignores expected, fence ignores every field
fetch 00000104 00000000 0 5a5a0104
fetch 0000010c 00000000 0 5a5a010c
fetch 00000200 00000000 0 5a5a0200
fetch 00000214 00000000 0 5a5a0214
fetch 00000228 00000000 0 5a5a0228
fetch 0000023c 00000000 0 5a5a023c
store 00000300 a1b2c3d4 5 00000000
load  00000300 00000000 0 5ab203d4
store 00000304 11223344 c 00000000
load  00000304 00000000 0 11220304
fetch 00000400 00000000 0 5a5a0400
store 00000404 deadbeef f 00000000
fetch 00000404 00000000 0 5a5a0404
fence 00000000 00000000 0 00000000
fetch 00000404 00000000 0 deadbeef
fetch 00000084 00000000 0 5a5a0084
fetch 00000188 00000000 0 5a5a0188
fetch 0000028c 00000000 0 5a5a028c
fetch 00000380 00000000 0 5a5a0380
fetch 00000484 00000000 0 5a5a0484
fetch 00000084 00000000 0 5a5a0084
fetch 00000188 00000000 0 5a5a0188
fetch 0000028c 00000000 0 5a5a028c
fetch 00000380 00000000 0 5a5a0380
fetch 00000484 00000000 0 5a5a0484
both  00000500 00000000 0 5a5a0500
both  00000614 00000000 0 5a5a0614

// File: tb/tb_fetch_mem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_mem;

	logic        clock;
	logic        reset;
	logic        ifu_valid;
	logic [31:0] ifu_addr;
	logic        ifu_fence;
	logic        ifu_ready;
	logic [31:0] ifu_data;
	logic        dreq_valid;
	logic        dreq_write;
	logic [31:0] dreq_addr;
	logic [31:0] dreq_wdata;
	logic [3:0]  dreq_wstrb;
	logic        dreq_ready;
	logic [31:0] dreq_rdata;

	// cases from the data file
	string       case_op[$];
	logic [31:0] case_addr[$];
	logic [31:0] case_wdata[$];
	logic [3:0]  case_strb[$];
	logic [31:0] case_exp[$];
	logic        loaded;

	// line of the previous fetch, still resident unless a fence came between
	logic [27:0] last_line;
	logic        line_known;

	fetch_mem_top #(.SET_BITS(4), .MEM_WORDS(1024), .MEM_LATENCY(2)) dut (
		.clock, .reset,
		.ifu_valid_i(ifu_valid), .ifu_addr_i(ifu_addr), .ifu_fence_i(ifu_fence),
		.ifu_ready_o(ifu_ready), .ifu_data_o(ifu_data),
		.dreq_valid_i(dreq_valid), .dreq_write_i(dreq_write), .dreq_addr_i(dreq_addr),
		.dreq_wdata_i(dreq_wdata), .dreq_wstrb_i(dreq_wstrb),
		.dreq_ready_o(dreq_ready), .dreq_rdata_o(dreq_rdata)
	);

	always #5 clock = ~clock;

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			$display("Test failures found");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic load_cases();
		int          fd;
		int          code;
		logic        done;
		string       op;
		string       rest;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  strb;
		logic [31:0] expected;
		done = 1'b0;
		fd = $fopen("tb/fetch_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open the case file tb/fetch_cases.txt");
			$display("Test failures found");
			$fatal(1, "no cases");
		end else begin
			while (!done) begin
				code = $fscanf(fd, "%s", op);
				if (code != 1) begin
					done = 1'b1;
				end else if (op[0] == "#") begin
					code = $fgets(rest, fd); // rest of a comment line
				end else begin
					code = $fscanf(fd, "%h %h %h %h", addr, wdata, strb, expected);
					if (code != 4) begin
						$display("case file line starting with %s is malformed", op);
						$display("Test failures found");
						$fatal(1, "bad case file");
					end else begin
						case_op.push_back(op);
						case_addr.push_back(addr);
						case_wdata.push_back(wdata);
						case_strb.push_back(strb);
						case_exp.push_back(expected);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// drives the fetch port, the data port or both, and waits for every ready pulse
	task automatic run_access(input logic do_fetch, input logic do_data, input logic is_write,
			input logic [31:0] addr, input logic [31:0] wdata, input logic [3:0] strb,
			input logic [31:0] expected, input logic expect_hit);
		logic fetch_busy;
		logic data_busy;
		int   polls;
		fetch_busy = do_fetch;
		data_busy = do_data;
		polls = 0;
		@(posedge clock);
		#1;
		ifu_valid = do_fetch;
		ifu_addr = addr;
		dreq_valid = do_data;
		dreq_write = is_write;
		dreq_addr = addr;
		dreq_wdata = wdata;
		dreq_wstrb = strb;
		while (fetch_busy || data_busy) begin
			@(posedge clock);
			polls++;
			if (fetch_busy && ifu_ready) begin
				check_value("ifu_data_o", ifu_data, expected);
				if (expect_hit)
					check_value("hit latency in cycles", 32'(polls - 1), 32'd2);
				fetch_busy = 1'b0;
			end
			if (data_busy && dreq_ready) begin
				if (!is_write)
					check_value("dreq_rdata_o", dreq_rdata, expected);
				data_busy = 1'b0;
			end
			#1;
			if (!fetch_busy)
				ifu_valid = 1'b0;
			if (!data_busy)
				dreq_valid = 1'b0;
		end
	endtask

	task automatic pulse_fence();
		@(posedge clock);
		#1 ifu_fence = 1'b1;
		@(posedge clock);
		#1 ifu_fence = 1'b0;
		repeat (2) @(posedge clock); // fence state, then valid bits clear
	endtask

	task automatic run_case(input int idx);
		string       op;
		logic [31:0] addr;
		logic        expect_hit;
		op = case_op[idx];
		addr = case_addr[idx];
		expect_hit = line_known && (addr[31:4] == last_line);
		if (op == "fetch" || op == "both") begin
			run_access(1'b1, op == "both", 1'b0, addr, case_wdata[idx], case_strb[idx],
				case_exp[idx], expect_hit);
			last_line = addr[31:4];
			line_known = 1'b1;
		end else if (op == "load") begin
			run_access(1'b0, 1'b1, 1'b0, addr, case_wdata[idx], case_strb[idx],
				case_exp[idx], 1'b0);
		end else if (op == "store") begin
			run_access(1'b0, 1'b1, 1'b1, addr, case_wdata[idx], case_strb[idx],
				case_exp[idx], 1'b0);
		end else if (op == "fence") begin
			pulse_fence();
			line_known = 1'b0;
		end else begin
			$display("case %0d has an unknown operation %s", idx, op);
			$display("Test failures found");
			$fatal(1, "bad operation");
		end
	endtask

	initial begin
		wait (loaded);
		repeat (case_op.size() * 40) @(posedge clock);
		$display("the run timed out after %0d cycles", case_op.size() * 40);
		$display("Test failures found");
		$fatal(1, "timeout");
	end

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		ifu_valid = 1'b0;
		ifu_addr = '0;
		ifu_fence = 1'b0;
		dreq_valid = 1'b0;
		dreq_write = 1'b0;
		dreq_addr = '0;
		dreq_wdata = '0;
		dreq_wstrb = '0;
		last_line = '0;
		line_known = 1'b0;
		loaded = 1'b0;
		load_cases();
		loaded = 1'b1;
		repeat (3) @(posedge clock);
		#1 reset = 1'b0;
		for (int i = 0; i < case_op.size(); i++)
			run_case(i);
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire
